// ==== src/game_pkg.sv ====
//==================================================
// Game package: matrix geometry, game states,
// move opcodes and frog start and goal cells
//==================================================
package game_pkg;

	// Square LED matrix
	localparam int matrix_size = 8;

	// Row or column index
	typedef logic [2:0] row_t;

	// Whole matrix, row 0 at the bottom, bit c is column c
	typedef logic [matrix_size-1:0][matrix_size-1:0] frame_t;

	typedef logic [1:0] level_t;

	typedef enum logic [2:0] {
		game_idle = 3'd0,
		game_play = 3'd1,
		game_lost = 3'd2,
		game_next = 3'd3,
		game_won  = 3'd4
	} game_state_t;

	typedef enum logic [2:0] {
		move_none  = 3'd0,
		move_up    = 3'd1,
		move_down  = 3'd2,
		move_left  = 3'd3,
		move_right = 3'd4
	} move_t;

	// Frog enters on the bottom row, middle column
	localparam row_t start_row = 3'd0;
	localparam row_t start_col = 3'd4;
	localparam row_t goal_row  = 3'd7;

endpackage

// ==== src/pattern_pkg.sv ====
//==================================================
// Pattern package: lane images per level and the
// fixed lose, next-level and won screens
//==================================================
package pattern_pkg;

	localparam int level_count = 4;

	// Rows listed top (row 7) down to bottom (row 0)
	localparam game_pkg::frame_t level_lanes [level_count] = '{
		{8'b11011011, 8'b00000000, 8'b10001000, 8'b00100100,
		 8'b00000000, 8'b11001100, 8'b00000000, 8'b00000000},
		{8'b10011001, 8'b01000100, 8'b00000000, 8'b10000010,
		 8'b00010000, 8'b11100110, 8'b00000000, 8'b00000000},
		{8'b01011001, 8'b10110010, 8'b10000001, 8'b01100101,
		 8'b00000000, 8'b11001100, 8'b00100000, 8'b00000000},
		{8'b10011011, 8'b01110001, 8'b00001100, 8'b01100100,
		 8'b00000101, 8'b11001100, 8'b00000010, 8'b00000000}
	};

	//==================================================
	// Fixed screens
	//==================================================

	// Crossed eyes over a frown
	localparam game_pkg::frame_t screen_lose = {
		8'b10011001,
		8'b01100110,
		8'b01100110,
		8'b10011001,
		8'b00000000,
		8'b00111100,
		8'b01000010,
		8'b01000010
	};

	// Arrow toward the next level
	localparam game_pkg::frame_t screen_next = {
		8'b00001000,
		8'b00000100,
		8'b00000010,
		8'b11111111,
		8'b11111111,
		8'b00000010,
		8'b00000100,
		8'b00001000
	};

	localparam game_pkg::frame_t screen_won = {
		8'b00000000,
		8'b01100110,
		8'b01100110,
		8'b00000000,
		8'b01111110,
		8'b01111110,
		8'b00000000,
		8'b00000000
	};

endpackage

// ==== src/frog_position.sv ====
//==================================================
// Frog position: row and column register stepped
// by the move buttons during play
//==================================================
`timescale 1ns/1ps

module frog_position (
	input  logic                 clock_50,
	input  logic                 rst,
	input  logic                 load,
	input  logic                 up,
	input  logic                 down,
	input  logic                 left,
	input  logic                 right,
	input  game_pkg::game_state_t state,
	output game_pkg::row_t       frog_row,
	output game_pkg::row_t       frog_col,
	output logic                 at_goal
);

	localparam game_pkg::row_t top_row = game_pkg::row_t'(game_pkg::matrix_size - 1);

	game_pkg::move_t move;

	// Button decode, up has highest priority
	always_comb begin
		move = game_pkg::move_none;
		if (state == game_pkg::game_play) begin
			if (up)
				move = game_pkg::move_up;
			else if (down)
				move = game_pkg::move_down;
			else if (left)
				move = game_pkg::move_left;
			else if (right)
				move = game_pkg::move_right;
		end
	end

	always_ff @(posedge clock_50) begin
		if (rst || load) begin
			frog_row <= game_pkg::start_row;
			frog_col <= game_pkg::start_col;
		end else begin
			case (move)
				game_pkg::move_up:
					if (frog_row != top_row)
						frog_row <= frog_row + 3'd1;
				game_pkg::move_down:
					if (frog_row != 3'd0)
						frog_row <= frog_row - 3'd1;
				// Column wraps around in both directions
				game_pkg::move_left:  frog_col <= frog_col + 3'd1;
				game_pkg::move_right: frog_col <= frog_col - 3'd1;
				default: ;
			endcase
		end
	end

	assign at_goal = (frog_row == game_pkg::goal_row);

endmodule

// ==== src/lane_scroller.sv ====
//==================================================
// Lane scroller: obstacle rows loaded per level and
// rotated one column on every prescaler tick
//==================================================
`timescale 1ns/1ps

module lane_scroller #(
	parameter int tick_period = 2_000_000
) (
	input  logic                  clock_50,
	input  logic                  rst,
	input  logic                  load,
	input  game_pkg::level_t      load_level,
	input  game_pkg::game_state_t state,
	output game_pkg::frame_t      lanes
);

	localparam int cnt_w = (tick_period > 1) ? $clog2(tick_period) : 1;
	localparam logic [cnt_w-1:0] tick_last = cnt_w'(tick_period - 1);

	logic [cnt_w-1:0] tick_cnt;
	logic             tick;

	assign tick = (tick_cnt == tick_last);

	//==================================================
	// Prescaler, counts only during play
	//==================================================
	always_ff @(posedge clock_50) begin
		if (rst || load)
			tick_cnt <= '0;
		else if (state == game_pkg::game_play) begin
			if (tick)
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	//==================================================
	// Lane registers
	//==================================================
	always_ff @(posedge clock_50) begin
		if (rst)
			lanes <= '0;
		else if (load)
			lanes <= pattern_pkg::level_lanes[load_level];
		else if (state == game_pkg::game_play && tick) begin
			// Rotate left, bit 7 wraps into bit 0
			for (int r = 0; r < game_pkg::matrix_size; r++)
				lanes[r] <= {lanes[r][6:0], lanes[r][7]};
		end
	end

endmodule

// ==== src/game_fsm.sv ====
//==================================================
// Game FSM: idle, play and end screens, with the
// level counter advanced on each crossing
//==================================================
`timescale 1ns/1ps

module game_fsm (
	input  logic                  clock_50,
	input  logic                  rst,
	input  logic                  start,
	input  logic                  hit,
	input  logic                  at_goal,
	output game_pkg::game_state_t state,
	output game_pkg::level_t      level,
	output logic                  load,
	output game_pkg::level_t      load_level
);

	localparam game_pkg::level_t last_level =
		game_pkg::level_t'(pattern_pkg::level_count - 1);

	game_pkg::game_state_t state_next;
	game_pkg::level_t      level_next;

	// Start is taken in every state but play
	assign load = start && (state != game_pkg::game_play);

	// Resume the reached level only after a next-level screen
	assign load_level = (state == game_pkg::game_next) ? level : 2'd0;

	//==================================================
	// Next state
	//==================================================
	always_comb begin
		state_next = state;
		level_next = level;
		if (load) begin
			state_next = game_pkg::game_play;
			level_next = load_level;
		end else if (state == game_pkg::game_play) begin
			// Collision wins over reaching the goal
			if (hit)
				state_next = game_pkg::game_lost;
			else if (at_goal) begin
				if (level == last_level)
					state_next = game_pkg::game_won;
				else begin
					state_next = game_pkg::game_next;
					level_next = level + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge clock_50) begin
		if (rst) begin
			state <= game_pkg::game_idle;
			level <= 2'd0;
		end else begin
			state <= state_next;
			level <= level_next;
		end
	end

endmodule

// ==== src/matrix_compositor.sv ====
//==================================================
// Matrix compositor: frog overlay, collision check
// and the frame picked for each game state
//==================================================
`timescale 1ns/1ps

module matrix_compositor (
	input  game_pkg::game_state_t state,
	input  game_pkg::frame_t      lanes,
	input  game_pkg::row_t        frog_row,
	input  game_pkg::row_t        frog_col,
	output game_pkg::frame_t      frame,
	output logic                  hit
);

	game_pkg::frame_t overlay;

	// Single lit cell at the frog
	always_comb begin
		overlay = '0;
		overlay[frog_row][frog_col] = 1'b1;
	end

	assign hit = |(overlay & lanes);

	always_comb begin
		case (state)
			game_pkg::game_play: frame = lanes | overlay;
			game_pkg::game_lost: frame = pattern_pkg::screen_lose;
			game_pkg::game_next: frame = pattern_pkg::screen_next;
			game_pkg::game_won:  frame = pattern_pkg::screen_won;
			default:             frame = '0;
		endcase
	end

endmodule

// ==== src/matrix_scanner.sv ====
//==================================================
// Matrix scanner: one column address and its eight
// bits per clock toward the matrix driver
//==================================================
`timescale 1ns/1ps

module matrix_scanner (
	input  logic             clock_50,
	input  logic             rst,
	input  game_pkg::frame_t frame,
	output game_pkg::row_t   disp_addr,
	output logic [7:0]       disp_data
);

	game_pkg::row_t next_addr;
	game_pkg::row_t col_sel;
	logic [7:0]     column;

	assign next_addr = disp_addr + 3'd1;
	assign col_sel   = 3'd7 - next_addr;

	// Address 0 is column 7, data bit 7 is the bottom row
	always_comb begin
		for (int k = 0; k < 8; k++)
			column[k] = frame[7-k][col_sel];
	end

	always_ff @(posedge clock_50) begin
		if (rst) begin
			disp_addr <= 3'd0;
			disp_data <= 8'd0;
		end else begin
			disp_addr <= next_addr;
			disp_data <= column;
		end
	end

endmodule

// ==== src/frog_game_top.sv ====
//==================================================
// Frog lane-crossing game on an 8x8 LED matrix
//==================================================
`timescale 1ns/1ps

module frog_game_top #(
	parameter int tick_period = 2_000_000
) (
	input  logic                  clock_50,
	input  logic                  rst,
	input  logic                  start,
	input  logic                  up,
	input  logic                  down,
	input  logic                  left,
	input  logic                  right,
	output game_pkg::row_t        disp_addr,
	output logic [7:0]            disp_data,
	output game_pkg::game_state_t game_state,
	output game_pkg::level_t      level
);

	logic             load;
	game_pkg::level_t load_level;
	game_pkg::row_t   frog_row;
	game_pkg::row_t   frog_col;
	logic             at_goal;
	game_pkg::frame_t lanes;
	game_pkg::frame_t frame;
	logic             hit;

	game_fsm game_fsm_i (
		.clock_50   (clock_50),
		.rst        (rst),
		.start      (start),
		.hit        (hit),
		.at_goal    (at_goal),
		.state      (game_state),
		.level      (level),
		.load       (load),
		.load_level (load_level)
	);

	frog_position frog_position_i (
		.clock_50 (clock_50),
		.rst      (rst),
		.load     (load),
		.up       (up),
		.down     (down),
		.left     (left),
		.right    (right),
		.state    (game_state),
		.frog_row (frog_row),
		.frog_col (frog_col),
		.at_goal  (at_goal)
	);

	lane_scroller #(.tick_period(tick_period)) lane_scroller_i (
		.clock_50   (clock_50),
		.rst        (rst),
		.load       (load),
		.load_level (load_level),
		.state      (game_state),
		.lanes      (lanes)
	);

	matrix_compositor matrix_compositor_i (
		.state    (game_state),
		.lanes    (lanes),
		.frog_row (frog_row),
		.frog_col (frog_col),
		.frame    (frame),
		.hit      (hit)
	);

	matrix_scanner matrix_scanner_i (
		.clock_50  (clock_50),
		.rst       (rst),
		.frame     (frame),
		.disp_addr (disp_addr),
		.disp_data (disp_data)
	);

endmodule

// ==== test/frog_game_checker.sv ====
//==================================================
// Frog game checker: cycle model of the game and
// per-cycle comparison of the top level outputs
//==================================================
`timescale 1ns/1ps

module frog_game_checker #(
	parameter int tick_period = 12
) (
	input logic                  clock_50,
	input logic                  rst,
	input logic                  start,
	input logic                  up,
	input logic                  down,
	input logic                  left,
	input logic                  right,
	input game_pkg::row_t        disp_addr,
	input logic [7:0]            disp_data,
	input game_pkg::game_state_t game_state,
	input game_pkg::level_t      level
);

	game_pkg::game_state_t m_state;
	game_pkg::level_t      m_level;
	game_pkg::row_t        m_row;
	game_pkg::row_t        m_col;
	game_pkg::frame_t      m_lanes;
	int                    m_tick;
	game_pkg::row_t        m_addr;
	logic [7:0]            m_data;
	bit                    model_valid = 1'b0;
	int                    check_count = 0;
	int                    error_count = 0;

	// Data bit k is frame row 7-k at column 7-addr
	function automatic logic [7:0] column_bits(input game_pkg::frame_t f, input int addr);
		logic [7:0] col;
		for (int k = 0; k < 8; k++)
			col[k] = f[7 - k][7 - addr];
		return col;
	endfunction

	function automatic game_pkg::frame_t shown_frame();
		game_pkg::frame_t f;
		case (m_state)
			game_pkg::game_play: begin
				f = m_lanes;
				f[m_row][m_col] = 1'b1;
			end
			game_pkg::game_lost: f = pattern_pkg::screen_lose;
			game_pkg::game_next: f = pattern_pkg::screen_next;
			game_pkg::game_won:  f = pattern_pkg::screen_won;
			default:             f = '0;
		endcase
		return f;
	endfunction

	task automatic compare_output(input string what, input logic [7:0] got,
			input logic [7:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("[FAIL] %0t %s is %0h, expected %0h", $time, what, got, exp);
			error_count++;
		end
	endtask

	//==================================================
	// Model, stepped on every rising edge
	//==================================================
	always @(posedge clock_50) begin
		game_pkg::frame_t shown;
		logic             hit;
		logic             goal;
		logic             load;
		game_pkg::level_t new_level;
		if (rst) begin
			m_state = game_pkg::game_idle;
			m_level = 2'd0;
			m_row = 3'd0;
			m_col = 3'd4;
			m_lanes = '0;
			m_tick = 0;
			m_addr = 3'd0;
			m_data = 8'd0;
			model_valid = 1'b1;
		end else begin
			shown = shown_frame();
			hit = m_lanes[m_row][m_col];
			goal = (m_row == 3'd7);
			load = start && (m_state != game_pkg::game_play);
			new_level = (m_state == game_pkg::game_next) ? m_level : 2'd0;
			m_addr = m_addr + 3'd1;
			m_data = column_bits(shown, m_addr);
			if (load) begin
				m_row = 3'd0;
				m_col = 3'd4;
				m_lanes = pattern_pkg::level_lanes[new_level];
				m_tick = 0;
				m_state = game_pkg::game_play;
				m_level = new_level;
			end else if (m_state == game_pkg::game_play) begin
				// Up, down, left, right in falling priority
				if (up) begin
					if (m_row != 3'd7)
						m_row = m_row + 3'd1;
				end else if (down) begin
					if (m_row != 3'd0)
						m_row = m_row - 3'd1;
				end else if (left)
					m_col = m_col + 3'd1;
				else if (right)
					m_col = m_col - 3'd1;
				if (m_tick == tick_period - 1) begin
					for (int r = 0; r < 8; r++)
						m_lanes[r] = {m_lanes[r][6:0], m_lanes[r][7]};
					m_tick = 0;
				end else
					m_tick++;
				if (hit)
					m_state = game_pkg::game_lost;
				else if (goal) begin
					if (m_level == 2'd3)
						m_state = game_pkg::game_won;
					else begin
						m_state = game_pkg::game_next;
						m_level = m_level + 2'd1;
					end
				end
			end
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clock_50) begin
		if (model_valid) begin
			compare_output("game_state", game_state, m_state);
			compare_output("level", level, m_level);
			compare_output("disp_addr", disp_addr, m_addr);
			compare_output("disp_data", disp_data, m_data);
		end
	end

endmodule

// ==== test/frog_game_sva.sv ====
//==================================================
// Game FSM assertions, bound into game_fsm
//==================================================
`timescale 1ns/1ps

module frog_game_sva (
	input logic                  clock_50,
	input logic                  rst,
	input logic                  start,
	input logic                  hit,
	input logic                  at_goal,
	input game_pkg::game_state_t state,
	input game_pkg::level_t      level,
	input logic                  load,
	input game_pkg::level_t      load_level
);

	int assert_errors = 0;

	// Start outside play enters play at the loaded level
	load_on_start: assert property (@(posedge clock_50) disable iff (rst)
		(start && state != game_pkg::game_play) |=>
			(state == game_pkg::game_play && level == $past(load_level)))
	else begin
		$error("start outside play did not enter play at the loaded level");
		assert_errors++;
	end

	// Play ends only on a hit or on the goal row
	stay_in_play: assert property (@(posedge clock_50) disable iff (rst)
		(state == game_pkg::game_play && !hit && !at_goal) |=> state == game_pkg::game_play)
	else begin
		$error("play left without hit or goal");
		assert_errors++;
	end

	idle_after_reset: assert property (@(posedge clock_50)
		rst |=> state == game_pkg::game_idle)
	else begin
		$error("state not idle after reset");
		assert_errors++;
	end

	// Last level holds until a new game is loaded
	level_in_range: assert property (@(posedge clock_50) disable iff (rst)
		(!load && int'(level) == pattern_pkg::level_count - 1) |=>
			int'(level) == pattern_pkg::level_count - 1)
	else begin
		$error("level moved past the last level");
		assert_errors++;
	end

endmodule

bind game_fsm frog_game_sva frog_game_sva_i (.*);

// ==== test/frog_game_tb.sv ====
//==================================================
// Frog game testbench: reset, start, moves, a lost
// game and a crossing of all levels
//==================================================
`timescale 1ns/1ps

module frog_game_tb;

	localparam int tick_period = 12;
	// Sum of per-test cycle budgets, doubled
	localparam int timeout_cycles = 2 * (20 + 4 * tick_period + 230 + 100 +
		pattern_pkg::level_count * (8 * 3 * tick_period + 30));

	logic clock_50 = 1'b0;
	logic rst = 1'b1;
	logic start = 1'b0;
	logic up = 1'b0;
	logic down = 1'b0;
	logic left = 1'b0;
	logic right = 1'b0;

	game_pkg::row_t        disp_addr;
	logic [7:0]            disp_data;
	game_pkg::game_state_t game_state;
	game_pkg::level_t      level;

	logic [31:0] rng = 32'd83;
	int          tb_errors = 0;
	int          tests_failed = 0;
	int          cycle_count = 0;

	frog_game_top #(.tick_period(tick_period)) frog_game_top_i (.*);
	frog_game_checker #(.tick_period(tick_period)) frog_game_checker_i (.*);

	initial begin
		forever #2 clock_50 = ~clock_50;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic int total_errors();
		return tb_errors + frog_game_checker_i.error_count +
			frog_game_top_i.game_fsm_i.frog_game_sva_i.assert_errors;
	endfunction

	// Inputs change 1 ns after the edge and are taken at the next one
	task automatic next_cycle();
		@(posedge clock_50);
		#1;
	endtask

	task automatic expect_equal(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] %0t %s is %0d, expected %0d", $time, what, got, exp);
			tb_errors++;
		end
	endtask

	task automatic wait_for_state(input game_pkg::game_state_t target, input int limit);
		int n;
		n = 0;
		while (game_state != target && n < limit) begin
			next_cycle();
			n++;
		end
		if (game_state != target) begin
			$display("state %0d not reached within %0d cycles", target, limit);
			tb_errors++;
		end
	endtask

	task automatic press_start();
		{start, up, down, left, right} = 5'b10000;
		next_cycle();
		start = 1'b0;
		wait_for_state(game_pkg::game_play, 2);
	endtask

	task automatic finish_test(input string name, input int mark);
		if (total_errors() == mark)
			$display("test %s: passed", name);
		else begin
			$display("test %s: failed, %0d errors", name, total_errors() - mark);
			tests_failed++;
		end
	endtask

	//==================================================
	// Safe steering from the checker's model
	//==================================================
	function automatic game_pkg::frame_t lanes_after_edge();
		game_pkg::frame_t l;
		l = frog_game_checker_i.m_lanes;
		if (frog_game_checker_i.m_tick == tick_period - 1)
			for (int r = 0; r < 8; r++)
				l[r] = {l[r][6:0], l[r][7]};
		return l;
	endfunction

	// Mostly up when clear, else a random safe step
	function automatic logic [4:0] crossing_move(input logic [31:0] r);
		game_pkg::frame_t l;
		game_pkg::row_t   row;
		game_pkg::row_t   col;
		l = lanes_after_edge();
		row = frog_game_checker_i.m_row;
		col = frog_game_checker_i.m_col;
		if (r[3:2] != 2'b00 && !l[row + 3'd1][col])
			return 5'b01000;
		case (r[1:0])
			2'd0:
				if (!l[row][col + 3'd1])
					return 5'b00010;
			2'd1:
				if (!l[row][col - 3'd1])
					return 5'b00001;
			2'd2:
				if (row != 3'd0 && !l[row - 3'd1][col])
					return 5'b00100;
			default: ;
		endcase
		if (!l[row][col])
			return 5'b00000;
		// Rotation due, moving along with the lanes is always clear
		return 5'b00010;
	endfunction

	task automatic cross_level();
		int n;
		n = 0;
		while (frog_game_checker_i.m_row != 3'd7 && n < 8 * 6 * tick_period &&
				frog_game_checker_i.m_state == game_pkg::game_play) begin
			rng = xorshift32(rng);
			{start, up, down, left, right} = crossing_move(rng);
			next_cycle();
			n++;
		end
		{start, up, down, left, right} = 5'b00000;
	endtask

	//==================================================
	// Tests
	//==================================================
	initial begin
		int               mark;
		logic [7:0]       seen;
		logic [3:0]       btn;
		game_pkg::frame_t ahead;
		repeat (2) @(posedge clock_50);
		#1;
		rst = 1'b0;

		mark = total_errors();
		seen = 8'h00;
		for (int i = 0; i < 8; i++) begin
			rng = xorshift32(rng);
			{start, up, down, left, right} = {1'b0, rng[3:0]};
			next_cycle();
			expect_equal("idle disp_data", disp_data, 0);
			seen[disp_addr] = 1'b1;
		end
		expect_equal("game_state", game_state, game_pkg::game_idle);
		expect_equal("level", level, 0);
		expect_equal("scanned address mask", seen, 8'hff);
		finish_test("reset and idle scan", mark);

		mark = total_errors();
		press_start();
		expect_equal("level", level, 0);
		repeat (4 * tick_period) next_cycle();
		expect_equal("game_state", game_state, game_pkg::game_play);
		finish_test("start and lane rotation", mark);

		mark = total_errors();
		for (int i = 0; i < 200; i++) begin
			rng = xorshift32(rng);
			btn = rng[3:0];
			// Rows 0 and 1 are empty in level 0
			if (frog_game_checker_i.m_row != 3'd0)
				btn[3] = 1'b0;
			{start, up, down, left, right} = {1'b0, btn};
			next_cycle();
		end
		{start, up, down, left, right} = 5'b00100;
		repeat (3) next_cycle();
		{start, up, down, left, right} = 5'b00010;
		repeat (9) next_cycle();
		{start, up, down, left, right} = 5'b00000;
		next_cycle();
		expect_equal("game_state", game_state, game_pkg::game_play);
		finish_test("moves in play", mark);

		mark = total_errors();
		for (int i = 0; i < 60 && frog_game_checker_i.m_state == game_pkg::game_play;
				i++) begin
			ahead = lanes_after_edge();
			if (frog_game_checker_i.m_row == 3'd0 || ahead[2][frog_game_checker_i.m_col])
				{start, up, down, left, right} = 5'b01000;
			else
				{start, up, down, left, right} = 5'b00010;
			next_cycle();
		end
		{start, up, down, left, right} = 5'b00000;
		wait_for_state(game_pkg::game_lost, 4);
		for (int i = 0; i < 10; i++) begin
			rng = xorshift32(rng);
			{start, up, down, left, right} = {1'b0, rng[3:0]};
			next_cycle();
		end
		expect_equal("game_state", game_state, game_pkg::game_lost);
		press_start();
		expect_equal("level", level, 0);
		finish_test("collision and restart", mark);

		mark = total_errors();
		for (int lvl = 0; lvl < pattern_pkg::level_count; lvl++) begin
			expect_equal("level", level, lvl);
			cross_level();
			if (lvl == pattern_pkg::level_count - 1) begin
				wait_for_state(game_pkg::game_won, 4);
				expect_equal("level", level, lvl);
			end else begin
				wait_for_state(game_pkg::game_next, 4);
				expect_equal("level", level, lvl + 1);
			end
			// One full sweep of the end screen
			repeat (10) next_cycle();
			press_start();
		end
		expect_equal("level", level, 0);
		finish_test("level crossings and win", mark);

		$display("tests 5, failed %0d, checks %0d, errors %0d", tests_failed,
			frog_game_checker_i.check_count, total_errors());
		if (total_errors() == 0 && tests_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge clock_50);
			cycle_count++;
		end
		$display("run stopped after %0d cycles without finishing", cycle_count);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
src/game_pkg.sv
src/pattern_pkg.sv
src/frog_position.sv
src/lane_scroller.sv
src/game_fsm.sv
src/matrix_compositor.sv
src/matrix_scanner.sv
src/frog_game_top.sv
test/frog_game_checker.sv
test/frog_game_sva.sv
test/frog_game_tb.sv
